// File: channel/channel_ctrl.sv
/* One pixel channel: takes a hit or periodic trigger, drives the ADC
   sample line, captures the conversion and pushes a timestamped event. */
`default_nettype none

module channel_ctrl (
    input  logic                          clk,
    input  logic                          rst_i,
    input  larpix_event_pkg::channel_id_t channel_id_i,   // fixed per instance
    input  larpix_cfg_pkg::chip_id_t      chip_id_i,
    input  logic                          masked_i,       // high ignores triggers
    input  logic                          hit_i,          // discriminator fired
    input  logic                          periodic_trigger_i,
    input  larpix_event_pkg::timestamp_t  timestamp_i,
    input  logic                          done_i,         // adc conversion finished
    input  larpix_event_pkg::adc_word_t   dout_i,
    input  logic                          fifo_full_i,    // local fifo full
    output logic                          sample_o,       // high while sampling
    output logic                          push_o,
    output larpix_event_pkg::event_word_t event_o
);
    import larpix_event_pkg::*;

    chan_state_t state_q;
    trig_src_t   trig_src_q;                              // latched at trigger
    timestamp_t  timestamp_q;                             // latched at trigger
    adc_word_t   adc_q;                                   // latched on done
    logic        trigger;

    // a full local fifo drops the trigger, the event is lost
    assign trigger = !masked_i && !fifo_full_i && (hit_i || periodic_trigger_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= CH_IDLE;
        end else begin
            case (state_q)
                CH_IDLE: begin
                    if (trigger) begin
                        state_q <= CH_SAMPLE;
                    end
                end
                CH_SAMPLE: begin
                    if (done_i) begin                     // latency set by the adc
                        state_q <= CH_STORE;
                    end
                end
                CH_STORE: begin
                    state_q <= CH_IDLE;                   // push happens here
                end
                default: begin
                    state_q <= CH_IDLE;
                end
            endcase
        end
    end

    // event payload
    always_ff @(posedge clk) begin
        if (state_q == CH_IDLE && trigger) begin
            timestamp_q <= timestamp_i;
            trig_src_q  <= periodic_trigger_i ? TRIG_PERIODIC : TRIG_NATURAL; // periodic wins
        end
        if (state_q == CH_SAMPLE && done_i) begin
            adc_q <= dout_i;
        end
    end

    assign sample_o = (state_q == CH_SAMPLE);
    assign push_o   = (state_q == CH_STORE);
    assign event_o  = {chip_id_i, channel_id_i, trig_src_q, timestamp_q, adc_q};

    // fifo can only drain while we sample, so it must have room at push
    a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
        !(push_o && fifo_full_i));

endmodule

`default_nettype wire

// File: common/larpix_cfg_pkg.sv
/* Register-map constants and configuration field types.
   Shared by the register map and the top level. */
`default_nettype none

package larpix_cfg_pkg;

    localparam int REG_NUM = 16;            // number of 8-bit registers

    typedef logic [3:0]  reg_addr_t;        // covers all REG_NUM registers
    typedef logic [7:0]  reg_word_t;
    typedef logic [7:0]  chip_id_t;
    typedef logic [15:0] period_t;          // periodic trigger spacing, clock cycles

    //////////////////////////////////////////////////////////////////////
    // register addresses
    //////////////////////////////////////////////////////////////////////

    localparam reg_addr_t ADDR_CHIP_ID      = 4'd0;
    localparam reg_addr_t ADDR_CHANNEL_MASK = 4'd1; // high bit masks channel
    localparam reg_addr_t ADDR_TRIG_MODES   = 4'd2; // bit 0 = periodic enable
    localparam reg_addr_t ADDR_PER_TRIG_LO  = 4'd3;
    localparam reg_addr_t ADDR_PER_TRIG_HI  = 4'd4;

    // reset values, every other register clears to 0
    localparam chip_id_t DEFAULT_CHIP_ID = 8'd1;
    localparam period_t  DEFAULT_PERIOD  = 16'd1000;

endpackage

`default_nettype wire

// File: common/larpix_event_pkg.sv
/* Event word layout, its field types and the channel FSM states.
   Used by the channels, the FIFOs and the top level. */
`default_nettype none

package larpix_event_pkg;

    localparam int ADC_BITS        = 10;
    localparam int TIMESTAMP_BITS  = 24;
    localparam int CHANNEL_ID_BITS = 6;
    localparam int EVENT_BITS      = 50; // chip 8 + chan 6 + src 2 + ts 24 + adc 10

    typedef logic [ADC_BITS-1:0]        adc_word_t;
    typedef logic [TIMESTAMP_BITS-1:0]  timestamp_t;
    typedef logic [CHANNEL_ID_BITS-1:0] channel_id_t;

    typedef enum logic [1:0] {
        TRIG_NATURAL  = 2'd0,               // discriminator hit
        TRIG_PERIODIC = 2'd1                // internal pulser
    } trig_src_t;

    // msb to lsb: chip id, channel id, trigger source, timestamp, adc word
    typedef logic [EVENT_BITS-1:0] event_word_t;

    typedef enum logic [1:0] {
        CH_IDLE,                            // waiting for trigger
        CH_SAMPLE,                          // sample high, waiting on adc done
        CH_STORE                            // push event to local fifo
    } chan_state_t;

endpackage

`default_nettype wire

// File: config/config_regmap.sv
/* Configuration register file with a parallel write port and a
   combinational read port; decodes the fields the core uses. */
`default_nettype none

module config_regmap #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      cfg_we_i,          // write strobe
    input  larpix_cfg_pkg::reg_addr_t cfg_addr_i,
    input  larpix_cfg_pkg::reg_word_t cfg_wdata_i,
    output larpix_cfg_pkg::reg_word_t cfg_rdata_o,       // addressed register
    output larpix_cfg_pkg::chip_id_t  chip_id_o,
    output logic [NUM_CHANNELS-1:0]   channel_mask_o,    // high disables channel
    output logic                      periodic_enable_o,
    output larpix_cfg_pkg::period_t   periodic_period_o
);
    import larpix_cfg_pkg::*;

    reg_word_t regs_q [REG_NUM];                         // register storage

    //////////////////////////////////////////////////////////////////////
    // storage, defaults on reset
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
            regs_q[ADDR_CHIP_ID]     <= DEFAULT_CHIP_ID;
            regs_q[ADDR_PER_TRIG_LO] <= DEFAULT_PERIOD[7:0];
            regs_q[ADDR_PER_TRIG_HI] <= DEFAULT_PERIOD[15:8];
        end else if (cfg_we_i) begin
            regs_q[cfg_addr_i] <= cfg_wdata_i;           // spare addresses just store
        end
    end

    assign cfg_rdata_o = regs_q[cfg_addr_i];

    //////////////////////////////////////////////////////////////////////
    // field decode
    //////////////////////////////////////////////////////////////////////

    assign chip_id_o         = regs_q[ADDR_CHIP_ID];
    assign channel_mask_o    = regs_q[ADDR_CHANNEL_MASK][NUM_CHANNELS-1:0];
    assign periodic_enable_o = regs_q[ADDR_TRIG_MODES][0];
    assign periodic_period_o = {regs_q[ADDR_PER_TRIG_HI], regs_q[ADDR_PER_TRIG_LO]};

endmodule

`default_nettype wire

// File: sim.f
common/larpix_cfg_pkg.sv
common/larpix_event_pkg.sv
config/config_regmap.sv
channel/channel_ctrl.sv
src/event_fifo.sv
src/event_router.sv
src/trigger_timing.sv
src/digital_core.sv
tb/tb_digital_core.sv

// File: src/digital_core.sv
/* Top of the reduced pixel readout core: register map, timing, the
   channels with their local FIFOs, the router and the shared FIFO. */
`default_nettype none

module digital_core #(
    parameter int NUM_CHANNELS      = 4,            // at most 8, one mask register
    parameter int LOCAL_FIFO_DEPTH  = 2,
    parameter int SHARED_FIFO_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          cfg_we_i,
    input  larpix_cfg_pkg::reg_addr_t     cfg_addr_i,
    input  larpix_cfg_pkg::reg_word_t     cfg_wdata_i,
    output larpix_cfg_pkg::reg_word_t     cfg_rdata_o,
    input  logic [NUM_CHANNELS-1:0]       hit_i,    // discriminator outputs
    input  logic [NUM_CHANNELS-1:0]       done_i,   // adc conversion done
    input  larpix_event_pkg::adc_word_t   dout_i [NUM_CHANNELS],
    output logic [NUM_CHANNELS-1:0]       sample_o, // to analog sample switch
    input  logic                          rd_i,     // pop shared fifo
    output larpix_event_pkg::event_word_t event_o,  // shared fifo head
    output logic                          empty_o
);
    import larpix_cfg_pkg::*;
    import larpix_event_pkg::*;

    chip_id_t                chip_id;
    logic [NUM_CHANNELS-1:0] channel_mask;
    logic                    periodic_enable;
    period_t                 periodic_period;
    timestamp_t              timestamp;
    logic                    periodic_trigger;

    logic [NUM_CHANNELS-1:0] local_push;
    logic [NUM_CHANNELS-1:0] local_full;
    logic [NUM_CHANNELS-1:0] local_empty;
    logic [NUM_CHANNELS-1:0] local_pop;
    event_word_t             local_event [NUM_CHANNELS]; // channel to fifo
    event_word_t             local_head [NUM_CHANNELS];  // fifo to router

    logic                    shared_push;
    event_word_t             shared_data;
    logic                    shared_full;
    logic                    shared_pop;

    assign shared_pop = rd_i && !empty_o;                // read while empty ignored

    //////////////////////////////////////////////////////////////////////
    // configuration and timing
    //////////////////////////////////////////////////////////////////////

    config_regmap #(
        .NUM_CHANNELS      (NUM_CHANNELS)
    ) u_config_regmap (
        .clk               (clk),
        .rst_i             (rst_i),
        .cfg_we_i          (cfg_we_i),
        .cfg_addr_i        (cfg_addr_i),
        .cfg_wdata_i       (cfg_wdata_i),
        .cfg_rdata_o       (cfg_rdata_o),
        .chip_id_o         (chip_id),
        .channel_mask_o    (channel_mask),
        .periodic_enable_o (periodic_enable),
        .periodic_period_o (periodic_period)
    );

    trigger_timing u_trigger_timing (
        .clk                (clk),
        .rst_i              (rst_i),
        .periodic_enable_i  (periodic_enable),
        .periodic_period_i  (periodic_period),
        .timestamp_o        (timestamp),
        .periodic_trigger_o (periodic_trigger)
    );

    //////////////////////////////////////////////////////////////////////
    // channels and local fifos
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
        channel_ctrl u_channel_ctrl (
            .clk                (clk),
            .rst_i              (rst_i),
            .channel_id_i       (channel_id_t'(g)),
            .chip_id_i          (chip_id),
            .masked_i           (channel_mask[g]),
            .hit_i              (hit_i[g]),
            .periodic_trigger_i (periodic_trigger),
            .timestamp_i        (timestamp),
            .done_i             (done_i[g]),
            .dout_i             (dout_i[g]),
            .fifo_full_i        (local_full[g]),
            .sample_o           (sample_o[g]),
            .push_o             (local_push[g]),
            .event_o            (local_event[g])
        );

        event_fifo #(
            .DEPTH   (LOCAL_FIFO_DEPTH)
        ) u_local_fifo (
            .clk     (clk),
            .rst_i   (rst_i),
            .push_i  (local_push[g]),
            .data_i  (local_event[g]),
            .pop_i   (local_pop[g]),
            .data_o  (local_head[g]),
            .empty_o (local_empty[g]),
            .full_o  (local_full[g])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // routing to shared readout fifo
    //////////////////////////////////////////////////////////////////////

    event_router #(
        .NUM_CHANNELS  (NUM_CHANNELS)
    ) u_event_router (
        .clk           (clk),
        .rst_i         (rst_i),
        .local_empty_i (local_empty),
        .local_data_i  (local_head),
        .local_pop_o   (local_pop),
        .shared_full_i (shared_full),
        .shared_push_o (shared_push),
        .shared_data_o (shared_data)
    );

    event_fifo #(
        .DEPTH   (SHARED_FIFO_DEPTH)
    ) u_shared_fifo (
        .clk     (clk),
        .rst_i   (rst_i),
        .push_i  (shared_push),
        .data_i  (shared_data),
        .pop_i   (shared_pop),
        .data_o  (event_o),
        .empty_o (empty_o),
        .full_o  (shared_full)
    );

endmodule

`default_nettype wire

// File: src/event_fifo.sv
/* Synchronous first-word-fall-through FIFO of event words. Serves as
   each channel's local FIFO and as the shared readout FIFO. */
`default_nettype none

module event_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          push_i,
    input  larpix_event_pkg::event_word_t data_i,
    input  logic                          pop_i,
    output larpix_event_pkg::event_word_t data_o,   // head, valid when not empty
    output logic                          empty_o,
    output logic                          full_o
);
    import larpix_event_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    event_word_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;                      // entries held

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;                              // wrap for non power of two
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // none, or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    a_no_push_full: assert property (@(posedge clk) disable iff (rst_i) push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: src/event_router.sv
/* Round-robin arbiter that moves one event per cycle from the channel
   FIFOs into the shared FIFO. */
`default_nettype none

module event_router #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [NUM_CHANNELS-1:0]       local_empty_i,
    input  larpix_event_pkg::event_word_t local_data_i [NUM_CHANNELS], // fifo heads
    output logic [NUM_CHANNELS-1:0]       local_pop_o,    // one-hot grant
    input  logic                          shared_full_i,
    output logic                          shared_push_o,
    output larpix_event_pkg::event_word_t shared_data_o
);
    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    logic [IDX_W-1:0] ptr_q;                              // highest-priority channel
    logic [IDX_W-1:0] grant_idx;
    logic             grant_valid;                        // some fifo has data

    // first non-empty fifo at or after the pointer
    always_comb begin
        int idx;
        grant_idx   = '0;
        grant_valid = 1'b0;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            idx = (int'(ptr_q) + k) % NUM_CHANNELS;
            if (!grant_valid && !local_empty_i[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    assign shared_push_o = grant_valid && !shared_full_i; // hold off when shared full
    assign shared_data_o = local_data_i[grant_idx];

    always_comb begin
        local_pop_o = '0;
        if (shared_push_o) begin
            local_pop_o[grant_idx] = 1'b1;                // pop and push same cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (shared_push_o) begin
            // move just past the winner
            ptr_q <= (grant_idx == IDX_W'(NUM_CHANNELS - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst_i) $onehot0(local_pop_o));

endmodule

`default_nettype wire

// File: src/trigger_timing.sv
/* Free-running event timestamp and the periodic trigger pulser
   shared by all channels. */
`default_nettype none

module trigger_timing (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         periodic_enable_i,
    input  larpix_cfg_pkg::period_t      periodic_period_i,  // pulse spacing
    output larpix_event_pkg::timestamp_t timestamp_o,
    output logic                         periodic_trigger_o  // one-cycle pulse
);
    import larpix_cfg_pkg::*;

    period_t period_cnt_q;                                    // cycles since last pulse
    period_t last_count;
    logic    period_reached;

    assign last_count     = periodic_period_i - 1'b1;
    assign period_reached = (period_cnt_q >= last_count);     // >= covers a shrunk period

    // timestamp, wraps at its width
    always_ff @(posedge clk) begin
        if (rst_i) begin
            timestamp_o <= '0;
        end else begin
            timestamp_o <= timestamp_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || !periodic_enable_i) begin
            period_cnt_q <= '0;                               // held while disabled
        end else if (period_reached) begin
            period_cnt_q <= '0;
        end else begin
            period_cnt_q <= period_cnt_q + 1'b1;
        end
    end

    assign periodic_trigger_o = periodic_enable_i && period_reached;

    a_pulse_single: assert property (@(posedge clk) disable iff (rst_i)
        (periodic_trigger_o && periodic_period_i > 16'd1) |=> !periodic_trigger_o);

endmodule

`default_nettype wire

// File: tb/digital_core_golden.txt
# W addr data | R addr expected | H chan adc | E chan src adc
# P cycles | D expect empty | X reset pulse; every number is hex
R 0 01
R 1 00
W 0 2a
R 0 2a
H 1 155
E 1 0 155
W 1 04
R 1 04
H 2 077
P 20
D
W 1 00
H 0 011
H 1 122
H 2 233
H 3 344
E 0 0 011
E 1 0 122
E 2 0 233
E 3 0 344
D
W 1 08
W 3 c8
W 4 00
R 4 00
W 2 01
E 0 1 005
E 1 1 015
E 2 1 025
P 1
E 0 1 005
E 1 1 015
E 2 1 025
H 0 3ff
X
R 0 01
R 1 00
R 2 00
R 3 e8
R 4 03
D

// File: tb/tb_digital_core.sv
/* Testbench for the readout core. Plays the command script in
   tb/digital_core_golden.txt against the DUT, with an ADC model on every channel. */
`default_nettype none

module tb_digital_core;
    import larpix_cfg_pkg::*;
    import larpix_event_pkg::*;

    localparam int NUM_CH     = 4;
    localparam int EVENT_WAIT = 1000;                     // cycles allowed for one event

    logic              clk;
    logic              rst_i;
    logic              cfg_we_i;
    reg_addr_t         cfg_addr_i;
    reg_word_t         cfg_wdata_i;
    reg_word_t         cfg_rdata_o;
    logic [NUM_CH-1:0] hit_i;
    logic [NUM_CH-1:0] done_i;
    adc_word_t         dout_i [NUM_CH];
    logic [NUM_CH-1:0] sample_o;
    logic              rd_i;
    event_word_t       event_o;
    logic              empty_o;

    int                fd;
    int                nlines;
    int                errors;
    int                checks;
    int                cycles;
    int                cycle_limit = 0;                   // set once the script is counted
    logic [31:0]       lcg_state = 32'h6df;
    logic [8*200-1:0]  line_buf;
    logic [7:0]        cmd;
    logic              script_done;

    // register state mirrors that follow script writes
    chip_id_t          chip_mirror;
    logic [7:0]        period_lo;
    logic [7:0]        period_hi;
    logic              periodic_on;
    logic [NUM_CH-1:0] hit_mask;                          // hits gathered for one cycle
    adc_word_t         pending_adc [NUM_CH];              // next natural conversion
    int                exp_chan [$];
    int                exp_src [$];
    int                exp_adc [$];
    timestamp_t        last_ts;
    timestamp_t        last_per_ts;                       // channel 0 periodic events
    logic              have_per_ts;

    // adc model
    logic [NUM_CH-1:0] busy;
    int                wait_cnt [NUM_CH];
    adc_word_t         adc_val [NUM_CH];

    digital_core #(
        .NUM_CHANNELS      (NUM_CH),
        .LOCAL_FIFO_DEPTH  (2),
        .SHARED_FIFO_DEPTH (16)
    ) dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .hit_i       (hit_i),
        .done_i      (done_i),
        .dout_i      (dout_i),
        .sample_o    (sample_o),
        .rd_i        (rd_i),
        .event_o     (event_o),
        .empty_o     (empty_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH time=%0t signal=%s actual=%0h expected=%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic reset_mirrors();
        chip_mirror = 8'h01;                              // defaults after reset
        period_lo   = 8'he8;
        period_hi   = 8'h03;
        periodic_on = 1'b0;
        last_ts     = '0;
        have_per_ts = 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            pending_adc[c] = '0;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        @(negedge clk);
        case (addr)
            ADDR_CHIP_ID:     chip_mirror = data;
            ADDR_TRIG_MODES:  periodic_on = data[0];
            ADDR_PER_TRIG_LO: period_lo   = data;
            ADDR_PER_TRIG_HI: period_hi   = data;
            default: ;
        endcase
        have_per_ts = 1'b0;                               // spacing restarts on new config
    endtask

    task automatic read_reg(input reg_addr_t addr, input reg_word_t expected);
        @(posedge clk);
        cfg_addr_i <= addr;
        @(negedge clk);                                   // read port is combinational
        check_value("cfg_rdata_o", cfg_rdata_o, expected);
    endtask

    task automatic apply_hits();
        if (hit_mask != '0) begin
            @(posedge clk);
            hit_i <= hit_mask;                            // all gathered hits in one cycle
            @(posedge clk);
            hit_i <= '0;
            @(negedge clk);
            hit_mask = '0;
        end
    endtask

    task automatic pulse_reset();
        int waited;
        waited = 0;
        // wait for a buffered event and a running conversion
        while ((empty_o || sample_o == '0) && waited < EVENT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (empty_o || sample_o == '0) begin
            errors++;
            $display("%0t: no buffered event with a channel sampling before the reset pulse",
                     $time);
        end
        @(posedge clk);
        rst_i <= 1'b1;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_value("empty_o", empty_o, 1);
        check_value("sample_o", sample_o, 0);
        reset_mirrors();
    endtask

    // pop queued expectations and match them by channel in any order
    task automatic match_events();
        event_word_t ev;
        int          waited;
        int          found;
        int          ev_chan;
        timestamp_t  ev_ts;
        while (exp_chan.size() > 0) begin
            waited = 0;
            while (empty_o && waited < EVENT_WAIT) begin
                @(negedge clk);
                waited++;
            end
            if (empty_o) begin
                errors++;
                $display("%0t: %0d expected events never reached the readout FIFO",
                         $time, exp_chan.size());
                exp_chan.delete();
                exp_src.delete();
                exp_adc.delete();
            end else begin
                ev = event_o;                             // fall-through head
                @(posedge clk);
                rd_i <= 1'b1;
                @(posedge clk);
                rd_i <= 1'b0;
                @(negedge clk);
                ev_chan = int'(ev[41:36]);                // chip 49:42, src 35:34
                ev_ts   = ev[33:10];                      // adc word in 9:0
                found   = -1;
                foreach (exp_chan[j]) begin
                    if (found < 0 && exp_chan[j] == ev_chan) begin
                        found = j;
                    end
                end
                if (found < 0) begin
                    errors++;
                    $display("%0t: event from channel %0d was not expected", $time, ev_chan);
                end else begin
                    check_value("event chip id", ev[49:42], chip_mirror);
                    check_value("event trigger source", ev[35:34], exp_src[found]);
                    check_value("event adc word", ev[9:0], exp_adc[found]);
                    check_value("event timestamp order", ev_ts >= last_ts, 1);
                    last_ts = ev_ts;
                    if (ev[35:34] == 2'd1 && ev_chan == 0) begin
                        if (have_per_ts) begin
                            check_value("periodic timestamp step",
                                        timestamp_t'(ev_ts - last_per_ts),
                                        {period_hi, period_lo});
                        end
                        last_per_ts = ev_ts;
                        have_per_ts = 1'b1;
                    end
                    exp_chan.delete(found);
                    exp_src.delete(found);
                    exp_adc.delete(found);
                end
            end
        end
    endtask

    task automatic run_command();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          n;
        if (cmd != "H") begin
            apply_hits();
        end
        if (cmd != "E") begin
            match_events();
        end
        case (cmd)
            "#": n = $fgets(line_buf, fd);                // column notes
            "W": begin
                n = $fscanf(fd, "%h %h", a, b);
                write_reg(a[3:0], b[7:0]);
            end
            "R": begin
                n = $fscanf(fd, "%h %h", a, b);
                read_reg(a[3:0], b[7:0]);
            end
            "H": begin
                n = $fscanf(fd, "%h %h", a, b);
                hit_mask[a] = 1'b1;
                pending_adc[a] = b[9:0];
            end
            "E": begin
                n = $fscanf(fd, "%h %h %h", a, b, c);
                exp_chan.push_back(int'(a));
                exp_src.push_back(int'(b));
                exp_adc.push_back(int'(c));
            end
            "P": begin
                n = $fscanf(fd, "%h", a);
                repeat (a) @(negedge clk);
            end
            "D": check_value("empty_o", empty_o, 1);
            "X": pulse_reset();
            default: begin
                errors++;
                $display("%0t: unknown script command '%c'", $time, cmd);
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // adc model with done 1 to 8 cycles after sample
    //////////////////////////////////////////////////////////////////////

    initial begin
        busy   = '0;
        done_i = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            dout_i[c] = '0;
        end
        forever begin
            @(posedge clk);
            for (int c = 0; c < NUM_CH; c++) begin
                if (rst_i) begin
                    busy[c] = 1'b0;
                    done_i[c] <= 1'b0;
                end else if (!busy[c]) begin
                    if (sample_o[c]) begin                // new conversion
                        busy[c]     = 1'b1;
                        wait_cnt[c] = int'(lcg_next() >> 16) % 8 + 1;
                        adc_val[c]  = periodic_on ? adc_word_t'(c * 16 + 5) : pending_adc[c];
                    end
                end else if (done_i[c]) begin
                    done_i[c] <= 1'b0;
                    busy[c] = 1'b0;
                end else if (wait_cnt[c] <= 1) begin
                    done_i[c] <= 1'b1;
                    dout_i[c] <= adc_val[c];
                end else begin
                    wait_cnt[c]--;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // script runner
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_i       = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        hit_i       = '0;
        rd_i        = 1'b0;
        errors      = 0;
        checks      = 0;
        nlines      = 0;
        hit_mask    = '0;
        script_done = 1'b0;
        reset_mirrors();
        fd = $fopen("tb/digital_core_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the script tb/digital_core_golden.txt");
            script_done = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line_buf, fd) != 0) begin
                    nlines++;
                end
            end
            $fclose(fd);
            fd = $fopen("tb/digital_core_golden.txt", "r");
        end
        cycle_limit = 20 * nlines + 4000;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        while (!script_done) begin
            if ($fscanf(fd, " %c", cmd) != 1) begin
                script_done = 1'b1;
            end else begin
                run_command();
            end
        end
        apply_hits();                                     // trailing groups
        match_events();
        $display("run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the script did not finish within %0d cycles", cycle_limit);
        $display("run finished: %0d checks, %0d errors", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
